// ==== common/a2bus_settings.svh ====
`ifndef A2BUS_SETTINGS_SVH
`define A2BUS_SETTINGS_SVH

// Nominal logic clock cycles in one bus phase at the card clock rate
`define A2_PHASE_COUNT 26

// Phase count in Phi1 where address and R/W have settled on the bus
`define A2_ADDR_COUNT 18

// Phase count in Phi0 where write data is stable on the bus
`define A2_DATA_COUNT 15

// Slack beyond two phases before a bus cycle is treated as extended
`define A2_EXTRA_COUNT 3

// Slot number of the card, slot 3 decodes device select at C0B0 to C0BF
`define A2_SLOT 3

// Number of bus records the queue can hold
`define A2_QUEUE_DEPTH 4

// Input slots in the register block, which is also the credit count
`define A2_CREDITS 2

`endif

// ==== common/a2bus_pkg.sv ====
package a2bus_pkg;

    // One Apple II bus cycle as seen by the card
    // The sampler builds it once per full Phi1/Phi0 cycle and the slot
    // register block consumes it after it has passed the record queue

    // The address is latched late in Phi1, when the 6502 has settled it
    // The data byte is latched in Phi0 and only on writes
    // On a read the data field repeats the last byte written on the bus,
    // because nothing on the card drives the bus and there is no read data
    // worth keeping

    // The rw_n bit follows the bus polarity, so a low bit marks a write

    // The extended bit belongs to the cycle before this one
    // It is set when the previous Phi1 rising edge to this Phi1 rising edge
    // took longer than two nominal phases plus the allowed slack
    // Stretched cycles come from slow memory, the IIgs or a stopped clock

    // Bit layout from the top down
    // addr is [25:10], data is [9:2], rw_n is [1] and extended is [0]
    typedef struct packed {
        // Full 16-bit CPU address
        logic [15:0] addr;
        // Byte written by the CPU, or the last written byte on a read
        logic [7:0]  data;
        // Low for a write cycle
        logic        rw_n;
        // Previous bus cycle ran longer than normal
        logic        extended;
    } bus_rec_t;

endpackage

// ==== verilog/a2bus_timing.sv ====
`timescale 1ns/100ps

module a2bus_timing (
    input  logic       a2bus_if,
    input  logic       rst_n_i,
    input  logic       a2_phi1_i,
    output logic       phi1_o,
    output logic       phi1_rise_o,
    output logic       phi1_fall_o,
    output logic [5:0] phase_count_o,
    output logic [6:0] cycle_time_o,
    output logic       sleep_o
);

    // Both counters stop at all ones instead of wrapping
    localparam logic [5:0] PHASE_MAX = 6'd63;
    localparam logic [6:0] CYCLE_MAX = 7'd127;

    logic       phi1_meta_r;
    logic       phi1_sync_r;
    logic       phi1_prev_r;
    logic       rise_r;
    logic       fall_r;
    logic [5:0] phase_cnt_r;
    logic [6:0] cycle_cnt_r;

    // Phi1 comes from the motherboard and is asynchronous to the logic clock
    // Two flops for metastability, a third one for edge detection
    // The edge pulses are registered so they line up with phi1_prev_r
    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            phi1_meta_r <= 1'b0;
            phi1_sync_r <= 1'b0;
            phi1_prev_r <= 1'b0;
            rise_r      <= 1'b0;
            fall_r      <= 1'b0;
        end else begin
            phi1_meta_r <= a2_phi1_i;
            phi1_sync_r <= phi1_meta_r;
            phi1_prev_r <= phi1_sync_r;
            rise_r      <= phi1_sync_r && !phi1_prev_r;
            fall_r      <= !phi1_sync_r && phi1_prev_r;
        end
    end

    // Cycles since the last Phi1 edge of either polarity
    // A full count means the bus clock has stopped
    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            phase_cnt_r <= '0;
        end else if (rise_r || fall_r) begin
            phase_cnt_r <= '0;
        end else if (phase_cnt_r != PHASE_MAX) begin
            phase_cnt_r <= phase_cnt_r + 1'b1;
        end
    end

    // Length of the whole bus cycle, restarted on each Phi1 rising edge
    // Holding at the top keeps a long stall from aliasing to a short cycle
    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            cycle_cnt_r <= '0;
        end else if (rise_r) begin
            cycle_cnt_r <= '0;
        end else if (cycle_cnt_r != CYCLE_MAX) begin
            cycle_cnt_r <= cycle_cnt_r + 1'b1;
        end
    end

    assign phi1_o        = phi1_prev_r;
    assign phi1_rise_o   = rise_r;
    assign phi1_fall_o   = fall_r;
    assign phase_count_o = phase_cnt_r;
    assign cycle_time_o  = cycle_cnt_r;
    assign sleep_o       = (phase_cnt_r == PHASE_MAX);

endmodule

// ==== apple_bus/apple_bus.sv ====
`timescale 1ns/100ps
`include "a2bus_settings.svh"

module apple_bus (
    input  logic                a2bus_if,
    input  logic                rst_n_i,
    input  logic                a2_phi1_i,
    input  logic [15:0]         a2_a_i,
    input  logic [7:0]          a2_d_i,
    input  logic                a2_rw_n_i,
    output logic                sleep_o,
    output logic                rec_valid_o,
    output a2bus_pkg::bus_rec_t rec_o
);

    // Sample points in phase counts, tuned for the synchronizer delay
    localparam logic [5:0] ADDR_COUNT = 6'(`A2_ADDR_COUNT);
    localparam logic [5:0] DATA_COUNT = 6'(`A2_DATA_COUNT);
    // A normal cycle measures two phases less one, anything at or past this is stretched
    localparam logic [6:0] EXT_LIMIT = 7'(2 * `A2_PHASE_COUNT + `A2_EXTRA_COUNT);

    logic        phi1_w;
    logic        phi1_rise_w;
    logic        phi1_fall_w;
    logic [5:0]  phase_count_w;
    logic [6:0]  cycle_time_w;
    logic        addr_strobe_w;
    logic        data_strobe_w;
    logic [15:0] addr_r;
    logic [7:0]  data_r;
    logic        rw_n_r;
    logic        addr_seen_r;
    logic        data_armed_r;
    logic        rise_seen_r;
    logic        ext_r;
    logic        rec_valid_r;

    a2bus_timing u_timing (
        .a2bus_if      (a2bus_if),
        .rst_n_i       (rst_n_i),
        .a2_phi1_i     (a2_phi1_i),
        .phi1_o        (phi1_w),
        .phi1_rise_o   (phi1_rise_w),
        .phi1_fall_o   (phi1_fall_w),
        .phase_count_o (phase_count_w),
        .cycle_time_o  (cycle_time_w),
        .sleep_o       (sleep_o)
    );

    // Address and R/W are valid late in Phi1
    assign addr_strobe_w = phi1_w && (phase_count_w == ADDR_COUNT);
    // Data is taken in Phi0, but only when this Phi0 follows a sampled Phi1
    assign data_strobe_w = !phi1_w && (phase_count_w == DATA_COUNT) && data_armed_r;

    // Bus latches, the data byte only moves on writes
    always_ff @(posedge a2bus_if) begin
        if (addr_strobe_w) begin
            addr_r <= a2_a_i;
            rw_n_r <= a2_rw_n_i;
        end
        if (data_strobe_w && !rw_n_r) begin
            data_r <= a2_d_i;
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            addr_seen_r  <= 1'b0;
            data_armed_r <= 1'b0;
            rise_seen_r  <= 1'b0;
            ext_r        <= 1'b0;
            rec_valid_r  <= 1'b0;
        end else begin
            // The record leaves the cycle after the data sample point
            rec_valid_r <= data_strobe_w;
            if (addr_strobe_w) begin
                addr_seen_r <= 1'b1;
            end
            // Falling Phi1 hands a sampled address over to the data phase
            if (phi1_fall_w) begin
                data_armed_r <= addr_seen_r;
                addr_seen_r  <= 1'b0;
            end else if (data_strobe_w) begin
                data_armed_r <= 1'b0;
            end
            // The first rising edge after reset has no whole cycle behind it
            if (phi1_rise_w) begin
                rise_seen_r <= 1'b1;
                ext_r       <= rise_seen_r && (cycle_time_w >= EXT_LIMIT);
            end
        end
    end

    assign rec_valid_o = rec_valid_r;
    assign rec_o = '{addr: addr_r, data: data_r, rw_n: rw_n_r, extended: ext_r};

endmodule

// ==== verilog/record_queue.sv ====
`timescale 1ns/100ps
`include "a2bus_settings.svh"

module record_queue (
    input  logic                a2bus_if,
    input  logic                rst_n_i,
    input  logic                in_valid_i,
    input  a2bus_pkg::bus_rec_t in_rec_i,
    input  logic                credit_return_i,
    output logic                out_valid_o,
    output a2bus_pkg::bus_rec_t out_rec_o,
    output logic                overrun_o
);

    import a2bus_pkg::*;

    localparam int DEPTH   = `A2_QUEUE_DEPTH;
    localparam int CREDITS = `A2_CREDITS;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int CRD_W   = $clog2(CREDITS + 1);

    bus_rec_t         mem_r [DEPTH];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [CNT_W-1:0] count_r;
    logic [CRD_W-1:0] credit_r;
    logic             overrun_r;
    logic             full_w;
    logic             push_w;
    logic             pop_w;

    // Pointer step with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // The bus cannot wait, so a record that finds the queue full is lost
    assign full_w = (count_r == CNT_W'(DEPTH));
    assign push_w = in_valid_i && !full_w;
    // Head goes out whenever the consumer still has a free input slot
    assign pop_w  = (count_r != '0) && (credit_r != '0);

    always_ff @(posedge a2bus_if) begin
        if (push_w) begin
            mem_r[wr_ptr_r] <= in_rec_i;
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            wr_ptr_r  <= '0;
            rd_ptr_r  <= '0;
            count_r   <= '0;
            credit_r  <= CRD_W'(CREDITS);
            overrun_r <= 1'b0;
        end else begin
            if (push_w) begin
                wr_ptr_r <= next_ptr(wr_ptr_r);
            end
            if (pop_w) begin
                rd_ptr_r <= next_ptr(rd_ptr_r);
            end
            count_r <= count_r + CNT_W'(push_w) - CNT_W'(pop_w);
            // A send and a returned credit in one cycle cancel out
            credit_r <= credit_r - CRD_W'(pop_w) + CRD_W'(credit_return_i);
            // Sticky until reset so software can see that records were lost
            overrun_r <= overrun_r || (in_valid_i && full_w);
        end
    end

    assign out_valid_o = pop_w;
    assign out_rec_o   = mem_r[rd_ptr_r];
    assign overrun_o   = overrun_r;

endmodule

// ==== verilog/slot_io_regs.sv ====
`timescale 1ns/100ps
`include "a2bus_settings.svh"

module slot_io_regs (
    input  logic                a2bus_if,
    input  logic                rst_n_i,
    input  logic                rec_valid_i,
    input  a2bus_pkg::bus_rec_t rec_i,
    input  logic                host_hold_i,
    input  logic [3:0]          host_addr_i,
    output logic                credit_return_o,
    output logic [7:0]          host_data_o,
    output logic [7:0]          write_count_o,
    output logic [7:0]          extended_count_o
);

    import a2bus_pkg::*;

    localparam int SLOTS  = `A2_CREDITS;
    localparam int PTR_W  = (SLOTS > 1) ? $clog2(SLOTS) : 1;
    localparam int CNT_W  = $clog2(SLOTS + 1);
    // Device select for slot n is C080 + n*16, compared on the upper 12 bits
    localparam logic [11:0] DEVSEL_BASE = 12'hC08 + 12'(`A2_SLOT);

    bus_rec_t         slot_r [SLOTS];
    logic [7:0]       regs_r [16];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [CNT_W-1:0] count_r;
    logic [7:0]       write_cnt_r;
    logic [7:0]       ext_cnt_r;
    bus_rec_t         head_w;
    logic             retire_w;
    logic             in_window_w;

    // The queue never sends more than there are slots, so no full check
    assign head_w      = slot_r[rd_ptr_r];
    assign retire_w    = (count_r != '0) && !host_hold_i;
    assign in_window_w = (head_w.addr[15:4] == DEVSEL_BASE);

    always_ff @(posedge a2bus_if) begin
        if (rec_valid_i) begin
            slot_r[wr_ptr_r] <= rec_i;
        end
        // Only writes into the device-select window touch the registers
        if (retire_w && !head_w.rw_n && in_window_w) begin
            regs_r[head_w.addr[3:0]] <= head_w.data;
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            wr_ptr_r    <= '0;
            rd_ptr_r    <= '0;
            count_r     <= '0;
            write_cnt_r <= '0;
            ext_cnt_r   <= '0;
        end else begin
            if (rec_valid_i) begin
                wr_ptr_r <= (wr_ptr_r == PTR_W'(SLOTS - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (retire_w) begin
                rd_ptr_r <= (rd_ptr_r == PTR_W'(SLOTS - 1)) ? '0 : rd_ptr_r + 1'b1;
                if (!head_w.rw_n && in_window_w) begin
                    write_cnt_r <= write_cnt_r + 1'b1;
                end
                // Counted on every record, reads and other addresses too
                if (head_w.extended) begin
                    ext_cnt_r <= ext_cnt_r + 1'b1;
                end
            end
            count_r <= count_r + CNT_W'(rec_valid_i) - CNT_W'(retire_w);
        end
    end

    // Each retired record frees one slot and goes back as a credit
    assign credit_return_o  = retire_w;
    assign host_data_o      = regs_r[host_addr_i];
    assign write_count_o    = write_cnt_r;
    assign extended_count_o = ext_cnt_r;

endmodule

// ==== verilog/a2_card_top.sv ====
`timescale 1ns/100ps

module a2_card_top (
    input  logic        a2bus_if,
    input  logic        rst_n_i,
    input  logic        a2_phi1_i,
    input  logic [15:0] a2_a_i,
    input  logic [7:0]  a2_d_i,
    input  logic        a2_rw_n_i,
    input  logic        host_hold_i,
    input  logic [3:0]  host_addr_i,
    output logic        sleep_o,
    output logic        overrun_o,
    output logic [7:0]  host_data_o,
    output logic [7:0]  write_count_o,
    output logic [7:0]  extended_count_o
);

    import a2bus_pkg::*;

    // Sampler to queue
    logic     rec_valid_w;
    bus_rec_t rec_w;
    // Queue to register block, with credits flowing back
    logic     q_valid_w;
    bus_rec_t q_rec_w;
    logic     credit_return_w;

    apple_bus u_apple_bus (
        .a2bus_if    (a2bus_if),
        .rst_n_i     (rst_n_i),
        .a2_phi1_i   (a2_phi1_i),
        .a2_a_i      (a2_a_i),
        .a2_d_i      (a2_d_i),
        .a2_rw_n_i   (a2_rw_n_i),
        .sleep_o     (sleep_o),
        .rec_valid_o (rec_valid_w),
        .rec_o       (rec_w)
    );

    record_queue u_record_queue (
        .a2bus_if        (a2bus_if),
        .rst_n_i         (rst_n_i),
        .in_valid_i      (rec_valid_w),
        .in_rec_i        (rec_w),
        .credit_return_i (credit_return_w),
        .out_valid_o     (q_valid_w),
        .out_rec_o       (q_rec_w),
        .overrun_o       (overrun_o)
    );

    slot_io_regs u_slot_io_regs (
        .a2bus_if         (a2bus_if),
        .rst_n_i          (rst_n_i),
        .rec_valid_i      (q_valid_w),
        .rec_i            (q_rec_w),
        .host_hold_i      (host_hold_i),
        .host_addr_i      (host_addr_i),
        .credit_return_o  (credit_return_w),
        .host_data_o      (host_data_o),
        .write_count_o    (write_count_o),
        .extended_count_o (extended_count_o)
    );

endmodule

// ==== tests/a2_card_asserts.sv ====
`timescale 1ns/100ps
`include "a2bus_settings.svh"

module a2_card_asserts #(
    parameter int CRD_W = $clog2(`A2_CREDITS + 1)
) (
    input logic             a2bus_if,
    input logic             rst_n_i,
    input logic             in_valid_i,
    input logic             out_valid_i,
    input logic             credit_return_i,
    input logic [CRD_W-1:0] credit_i,
    input logic             overrun_i
);

    localparam int IFL_W = CRD_W + 1;
    localparam int OCC_W = $clog2(`A2_QUEUE_DEPTH + 1);

    // Records handed to the register block and not yet retired there
    logic [IFL_W-1:0] in_flight_r;
    // Records waiting in the queue, counted from its ports alone
    logic [OCC_W-1:0] occ_r;
    logic             occ_full_w;

    assign occ_full_w = (occ_r == OCC_W'(`A2_QUEUE_DEPTH));

    always_ff @(posedge a2bus_if) begin
        if (!rst_n_i) begin
            in_flight_r <= '0;
            occ_r       <= '0;
        end else begin
            in_flight_r <= in_flight_r + IFL_W'(out_valid_i) - IFL_W'(credit_return_i);
            occ_r       <= occ_r + OCC_W'(in_valid_i && !occ_full_w) - OCC_W'(out_valid_i);
        end
    end

    // A record may only go to the register block while it has a free slot
    a_valid_needs_credit: assert property (@(posedge a2bus_if) disable iff (!rst_n_i)
        out_valid_i |-> (in_flight_r < IFL_W'(`A2_CREDITS)))
        else $error("record sent while every consumer slot was taken");

    // Returned credits can never add up to more slots than exist
    a_credit_bound: assert property (@(posedge a2bus_if) disable iff (!rst_n_i)
        credit_i <= CRD_W'(`A2_CREDITS))
        else $error("credit counter above the number of consumer slots");

    // A record that meets a full queue raises the flag and it stays up until reset
    a_overrun_sticky: assert property (@(posedge a2bus_if) disable iff (!rst_n_i)
        (overrun_i || (in_valid_i && occ_full_w)) |=> overrun_i)
        else $error("overrun flag missing after a drop or cleared without a reset");

endmodule

bind record_queue a2_card_asserts u_asserts (
    .a2bus_if        (a2bus_if),
    .rst_n_i         (rst_n_i),
    .in_valid_i      (in_valid_i),
    .out_valid_i     (out_valid_o),
    .credit_return_i (credit_return_i),
    .credit_i        (credit_r),
    .overrun_i       (overrun_o)
);

// ==== tests/a2_card_checker.sv ====
`timescale 1ns/100ps
`include "a2bus_settings.svh"

module a2_card_checker (
    input logic       sleep_i,
    input logic       overrun_i,
    input logic [7:0] host_data_i,
    input logic [7:0] write_count_i,
    input logic [7:0] extended_count_i
);

    import a2bus_pkg::*;

    // Device select window of the slot starts at C080 plus sixteen per slot
    localparam logic [15:0] WINDOW = 16'hC080 + 16'(16 * `A2_SLOT);
    // Records the card can park while the host holds it off
    localparam int BACKLOG = `A2_CREDITS + `A2_QUEUE_DEPTH;
    // Phase counter top plus a few cycles of synchronizer latency
    localparam int SLEEP_LOW = 63 + 5;

    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    logic [7:0]  model_regs [16];
    bit          reg_written [16];
    int          exp_writes   = 0;
    int          exp_extended = 0;
    bit          exp_overrun  = 0;
    bit          prev_stretched = 0;
    bit          have_prev = 0;
    int          held_run = 0;
    bus_rec_t    pending_q [$];

    task automatic compare(input string name, input string what, input int exp, input int act);
        check_count++;
        if (exp != act) begin
            error_count++;
            $display("** Error test %s: %s expected %0h actual %0h", name, what, exp, act);
        end
    endtask

    // One line per finished test
    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s failed", name);
        end
    endtask

    // Retire everything parked in the card in arrival order
    task automatic retire_pending();
        bus_rec_t rec;
        while (pending_q.size() > 0) begin
            rec = pending_q.pop_front();
            if (!rec.rw_n && rec.addr[15:4] == WINDOW[15:4]) begin
                model_regs[rec.addr[3:0]] = rec.data;
                reg_written[rec.addr[3:0]] = 1'b1;
                exp_writes++;
            end
            if (rec.extended) begin
                exp_extended++;
            end
        end
    endtask

    // Called at the end of each driven bus cycle in the middle of a clock low phase
    task automatic entry_done(input string name, input logic [15:0] addr,
                              input logic [7:0] data, input logic rw_n,
                              input int hi_extra, input int lo_extra, input logic hold);
        bus_rec_t rec;
        int       errs_before;
        errs_before = error_count;
        test_count++;
        rec.addr = addr;
        rec.data = data;
        rec.rw_n = rw_n;
        rec.extended = have_prev && prev_stretched;
        prev_stretched = (hi_extra + lo_extra) > `A2_EXTRA_COUNT;
        have_prev = 1'b1;
        if (hold) begin
            held_run++;
            // Beyond the backlog the queue is full and the record is lost
            if (held_run <= BACKLOG) begin
                pending_q.push_back(rec);
            end else begin
                exp_overrun = 1'b1;
            end
        end else begin
            held_run = 0;
            pending_q.push_back(rec);
            retire_pending();
        end
        compare(name, "write_count", exp_writes, write_count_i);
        compare(name, "extended_count", exp_extended, extended_count_i);
        compare(name, "overrun", exp_overrun, overrun_i);
        compare(name, "sleep", (`A2_PHASE_COUNT + lo_extra) >= SLEEP_LOW, sleep_i);
        report_test(name, errs_before);
    endtask

    task automatic check_reg(input int idx);
        string name;
        int    errs_before;
        if (reg_written[idx]) begin
            name = $sformatf("reg_%0h", idx);
            errs_before = error_count;
            test_count++;
            compare(name, "host_data", model_regs[idx], host_data_i);
            report_test(name, errs_before);
        end
    endtask

endmodule

// ==== tests/a2_card_tb.sv ====
`timescale 1ns/100ps
`include "a2bus_settings.svh"

module a2_card_tb;

    typedef struct {
        string       name;
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rw_n;
        int          hi_extra;
        int          lo_extra;
        logic        hold;
    } entry_t;

    localparam int N_ENTRIES = 28;
    localparam int N_IDLE    = 3;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        phi1;
    logic [15:0] addr;
    logic [7:0]  data;
    logic        rw_n;
    logic        hold;
    logic [3:0]  host_addr;
    logic        sleep;
    logic        overrun;
    logic [7:0]  host_data;
    logic [7:0]  write_count;
    logic [7:0]  extended_count;
    entry_t      table_q [N_ENTRIES];
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    always #5 clk = !clk;

    a2_card_top u_dut (
        .a2bus_if         (clk),
        .rst_n_i          (rst_n),
        .a2_phi1_i        (phi1),
        .a2_a_i           (addr),
        .a2_d_i           (data),
        .a2_rw_n_i        (rw_n),
        .host_hold_i      (hold),
        .host_addr_i      (host_addr),
        .sleep_o          (sleep),
        .overrun_o        (overrun),
        .host_data_o      (host_data),
        .write_count_o    (write_count),
        .extended_count_o (extended_count)
    );

    a2_card_checker u_check (
        .sleep_i          (sleep),
        .overrun_i        (overrun),
        .host_data_i      (host_data),
        .write_count_i    (write_count),
        .extended_count_i (extended_count)
    );

    function automatic entry_t make(input string name, input logic [15:0] a,
                                    input logic [7:0] d, input logic r,
                                    input int hi, input int lo, input logic h);
        entry_t e;
        e.name = name;
        e.addr = a;
        e.data = d;
        e.rw_n = r;
        e.hi_extra = hi;
        e.lo_extra = lo;
        e.hold = h;
        return e;
    endfunction

    task automatic fill_table();
        table_q[0]  = make("wr_c0b0", 16'hC0B0, 8'h11, 1'b0, 0, 0, 1'b0);
        table_q[1]  = make("wr_c0b5", 16'hC0B5, 8'hA5, 1'b0, 0, 0, 1'b0);
        table_q[2]  = make("rd_c0b5", 16'hC0B5, 8'hEE, 1'b1, 0, 0, 1'b0);
        table_q[3]  = make("wr_out_c0a5", 16'hC0A5, 8'h77, 1'b0, 0, 0, 1'b0);
        table_q[4]  = make("rd_out_c000", 16'hC000, 8'h00, 1'b1, 0, 0, 1'b0);
        table_q[5]  = make("wr_c0bf", 16'hC0BF, 8'h3C, 1'b0, 0, 0, 1'b0);
        // Phi1 stretched well past the allowance, so the next record is extended
        table_q[6]  = make("stretch", 16'hC050, 8'h00, 1'b1, 6, 0, 1'b0);
        table_q[7]  = make("after_stretch", 16'hC0B2, 8'h42, 1'b0, 0, 0, 1'b0);
        table_q[8]  = make("mild_stretch", 16'hC051, 8'h00, 1'b1, 2, 0, 1'b0);
        table_q[9]  = make("wr_c0b3", 16'hC0B3, 8'h99, 1'b0, 0, 0, 1'b0);
        // Five held cycles fit in the consumer slots plus the queue
        table_q[10] = make("hold_a", 16'hC0B8, 8'h01, 1'b0, 0, 0, 1'b1);
        table_q[11] = make("hold_b", 16'hC0B8, 8'h02, 1'b0, 0, 0, 1'b1);
        table_q[12] = make("hold_c", 16'hC0B9, 8'h03, 1'b0, 0, 0, 1'b1);
        table_q[13] = make("hold_d", 16'hC0B8, 8'h04, 1'b0, 0, 0, 1'b1);
        table_q[14] = make("hold_e", 16'hC0BA, 8'h05, 1'b0, 0, 0, 1'b1);
        table_q[15] = make("release", 16'hC0BB, 8'h06, 1'b0, 0, 0, 1'b0);
        // Eight held reads overflow the backlog by two
        table_q[16] = make("ovr_0", 16'hC030, 8'h00, 1'b1, 0, 0, 1'b1);
        table_q[17] = make("ovr_1", 16'hC030, 8'h00, 1'b1, 0, 0, 1'b1);
        table_q[18] = make("ovr_2", 16'hC030, 8'h00, 1'b1, 0, 0, 1'b1);
        table_q[19] = make("ovr_3", 16'hC030, 8'h00, 1'b1, 0, 0, 1'b1);
        table_q[20] = make("ovr_4", 16'hC030, 8'h00, 1'b1, 0, 0, 1'b1);
        table_q[21] = make("ovr_5", 16'hC030, 8'h00, 1'b1, 0, 0, 1'b1);
        table_q[22] = make("ovr_6", 16'hC030, 8'h00, 1'b1, 0, 0, 1'b1);
        table_q[23] = make("ovr_7", 16'hC030, 8'h00, 1'b1, 0, 0, 1'b1);
        table_q[24] = make("ovr_release", 16'hC0BC, 8'h07, 1'b0, 0, 0, 1'b0);
        // Bus clock stopped in Phi0 long enough for the phase counter to saturate
        table_q[25] = make("stall", 16'hC0B1, 8'h88, 1'b0, 0, 80, 1'b0);
        table_q[26] = make("wake", 16'hC0B4, 8'h44, 1'b0, 0, 0, 1'b0);
        table_q[27] = make("wr_c0b0_again", 16'hC0B0, 8'h12, 1'b0, 0, 0, 1'b0);
    endtask

    // One full bus cycle with Phi1 high then low and the bus held steady throughout
    task automatic drive_cycle(input entry_t e);
        @(posedge clk);
        phi1 <= 1'b1;
        addr <= e.addr;
        data <= e.data;
        rw_n <= e.rw_n;
        hold <= e.hold;
        repeat (`A2_PHASE_COUNT + e.hi_extra) @(posedge clk);
        phi1 <= 1'b0;
        repeat (`A2_PHASE_COUNT + e.lo_extra - 1) @(posedge clk);
        @(negedge clk);
        u_check.entry_done(e.name, e.addr, e.data, e.rw_n, e.hi_extra, e.lo_extra, e.hold);
    endtask

    // Random read somewhere outside the slot window
    function automatic entry_t idle_entry();
        logic [15:0] a;
        a = 16'($urandom);
        if (a[15:4] == 12'hC0B) begin
            a[12] = !a[12];
        end
        return make("idle", a, 8'h00, 1'b1, 0, 0, 1'b0);
    endfunction

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int total;
        void'($urandom(32'h9f50b720));
        rst_n = 1'b0;
        phi1 = 1'b0;
        addr = '0;
        data = '0;
        rw_n = 1'b1;
        hold = 1'b0;
        host_addr = '0;
        fill_table();
        total = 16 + 16 * 2 + N_IDLE * 2 * `A2_PHASE_COUNT;
        for (int i = 0; i < N_ENTRIES; i++) begin
            total += 2 * `A2_PHASE_COUNT + table_q[i].hi_extra + table_q[i].lo_extra;
        end
        cycle_limit = total + 200;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_ENTRIES; i++) begin
            drive_cycle(table_q[i]);
        end
        for (int i = 0; i < N_IDLE; i++) begin
            drive_cycle(idle_entry());
        end
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            host_addr <= 4'(i);
            @(negedge clk);
            u_check.check_reg(i);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 u_check.test_count, u_check.check_count, u_check.error_count);
        if (u_check.error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/a2bus_pkg.sv
verilog/a2bus_timing.sv
apple_bus/apple_bus.sv
verilog/record_queue.sv
verilog/slot_io_regs.sv
verilog/a2_card_top.sv
tests/a2_card_asserts.sv
tests/a2_card_checker.sv
tests/a2_card_tb.sv
